//--- sim.f
hdl/split_mult_pkg.sv
hdl/partial_mult.sv
hdl/partial_combine.sv
hdl/split_mult.sv
bench/split_mult_checker.sv
bench/tb_split_mult.sv

//--- bench/tb_split_mult.sv
`timescale 1ns/1ns

module tb_split_mult
	import split_mult_pkg::*;
();

	localparam int A_W       = DEF_A_W;  // Operand A width.
	localparam int B_W       = DEF_B_W;  // Operand B width.
	localparam int LO_W      = DEF_LO_W; // Split point.
	localparam int DRAIN_MAX = 20;       // Cycles allowed for the pipeline to empty.

	logic               clk;
	logic               arst_n;
	logic               in_valid;
	mult_mode_e         mode;
	logic [A_W-1:0]     data_a;
	logic [B_W-1:0]     data_b;
	logic [A_W+B_W-1:0] result;
	logic               out_valid;

	int     error_count;
	int     strobe_count;
	int     result_count;
	int     pending;
	integer seed = 32'hb1f; // Fixed seed for all random stimulus.
	int     sent;           // Strobes driven by this bench.
	int     bench_errors;   // Failures found at the end of the run.
	int     wait_cycles;

	// 8 ns clock.
	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	split_mult #(.A_W(A_W), .B_W(B_W), .LO_W(LO_W)) dut_i
	(
		.clk(clk), .arst_n(arst_n), .in_valid(in_valid), .mode(mode),
		.data_a(data_a), .data_b(data_b), .result(result), .out_valid(out_valid)
	);

	split_mult_checker #(.A_W(A_W), .B_W(B_W)) u_checker
	(
		.clk(clk), .arst_n(arst_n), .in_valid(in_valid), .mode(mode),
		.data_a(data_a), .data_b(data_b), .result(result), .out_valid(out_valid),
		.error_count(error_count), .strobe_count(strobe_count),
		.result_count(result_count), .pending(pending)
	);

	// Zero, one, all ones, most negative, largest positive.
	function automatic logic [31:0] corner_value(input int idx, input int w);
		case (idx)
			0:       corner_value = 32'd0;
			1:       corner_value = 32'd1;
			2:       corner_value = (32'd1 << w) - 32'd1;
			3:       corner_value = 32'd1 << (w - 1);
			default: corner_value = (32'd1 << (w - 1)) - 32'd1;
		endcase
	endfunction

	task automatic send(input logic [A_W-1:0] a, input logic [B_W-1:0] b, input mult_mode_e m);
		@(negedge clk);
		in_valid = 1'b1; // Held high for back-to-back calls.
		data_a   = a;
		data_b   = b;
		mode     = m;
		sent++;
	endtask

	// Zero operands while idle keep the pipeline registers at zero.
	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			in_valid = 1'b0;
			data_a   = '0;
			data_b   = '0;
			mode     = MODE_UU;
		end
	endtask

	task automatic send_random();
		logic [1:0] r;
		r = $random(seed); // Any of the four modes.
		send($random(seed), $random(seed), mult_mode_e'(r));
	endtask

	initial
	begin
		in_valid     = 1'b0;
		mode         = MODE_UU;
		data_a       = '0;
		data_b       = '0;
		arst_n       = 1'b0;
		sent         = 0;
		bench_errors = 0;
		repeat (5) @(posedge clk); // Reset held for 5 cycles.
		@(negedge clk);
		arst_n = 1'b1;
		idle(4); // Outputs must stay zero here.
		for (int m = 0; m < 4; m++)
			for (int i = 0; i < 5; i++)
				for (int j = 0; j < 5; j++)
					send(corner_value(i, A_W), corner_value(j, B_W), mult_mode_e'(m));
		idle(3);
		repeat (300) send_random(); // Back-to-back stream.
		idle(3);
		repeat (100)
		begin
			send_random();
			idle($unsigned($random(seed)) % 4); // Gap of 0 to 3 cycles.
		end
		idle(1);
		wait_cycles = 0;
		while (pending != 0 && wait_cycles < DRAIN_MAX)
		begin
			@(negedge clk);
			wait_cycles++;
		end
		if (pending != 0)
		begin
			bench_errors++;
			$display("Timed out with %0d results still missing", pending);
		end
		idle(6); // Catch stray out_valid pulses.
		if (result_count != sent)
		begin
			bench_errors++;
			$display("Sent %0d strobes but saw %0d out_valid pulses", sent, result_count);
		end
		$display("errors %0d, strobes %0d, results %0d",
			error_count + bench_errors, strobe_count, result_count);
		if (error_count + bench_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- bench/split_mult_checker.sv
`timescale 1ns/1ns

module split_mult_checker
	import split_mult_pkg::*;
#(
	parameter int A_W = DEF_A_W, // Width of data_a.
	parameter int B_W = DEF_B_W  // Width of data_b.
)
(
	input  logic               clk,          // DUT clock.
	input  logic               arst_n,       // DUT reset.
	input  logic               in_valid,     // Strobe into the DUT.
	input  mult_mode_e         mode,         // Signedness of the operands.
	input  logic [A_W-1:0]     data_a,       // Operand A.
	input  logic [B_W-1:0]     data_b,       // Operand B.
	input  logic [A_W+B_W-1:0] result,       // DUT product.
	input  logic               out_valid,    // DUT result strobe.
	output int                 error_count,  // Mismatches seen so far.
	output int                 strobe_count, // Transactions sent.
	output int                 result_count, // Every out_valid pulse seen.
	output int                 pending       // Transactions still in flight.
);

	localparam int P_W = A_W + B_W; // Product width.
	localparam int LAT = 2;         // Cycles from strobe to out_valid.

	logic [P_W-1:0] exp_q[$];       // Expected products with the oldest first.
	int             cyc_q[$];       // Cycle of each strobe.
	logic [P_W-1:0] exp_val;        // Head of the queue.
	int             sent_cyc;       // Strobe cycle of the head.
	int             cyc = 0;        // Rising edges since time zero.
	int             errs = 0;
	int             strobes = 0;
	int             results = 0;
	int             depth = 0;
	bit             seen_strobe = 0; // Set by the first transaction.

	assign error_count  = errs;
	assign strobe_count = strobes;
	assign result_count = results;
	assign pending      = depth;

	// A times B with each operand read by its mode letter and wrapped to P_W bits.
	function automatic logic [P_W-1:0] ref_product(input logic [A_W-1:0] a,
		input logic [B_W-1:0] b, input mult_mode_e m);
		longint av;
		longint bv;
		longint p;
		av = longint'(a); // Unsigned reading first.
		bv = longint'(b);
		if ((m == MODE_SU || m == MODE_SS) && a[A_W-1])
		begin
			av = av - (longint'(1) << A_W); // Two's complement value of A.
		end
		if ((m == MODE_US || m == MODE_SS) && b[B_W-1])
		begin
			bv = bv - (longint'(1) << B_W); // Same for B.
		end
		p = av * bv;
		return p[P_W-1:0];
	endfunction

	// Sampled before the DUT registers update on this edge.
	always @(posedge clk)
	begin
		// The first edge in reset clears registers that start unknown.
		if (cyc > 0 && !seen_strobe && (out_valid !== 1'b0 || result !== '0))
		begin
			errs++; // Outputs must stay quiet until traffic starts.
			if (out_valid !== 1'b0)
				$display("Fail out_valid before first strobe: expected 0x0, got 0x%h",
					out_valid);
			if (result !== '0)
				$display("Fail result before first strobe: expected 0x%h, got 0x%h",
					{P_W{1'b0}}, result);
		end
		else if (out_valid === 1'b1)
		begin
			results++; // Counted whether or not a strobe matches it.
			if (exp_q.size() == 0)
			begin
				errs++;
				$display("out_valid pulse arrived with no transaction in flight");
			end
			else
			begin
				exp_val  = exp_q.pop_front();
				sent_cyc = cyc_q.pop_front();
				if (result !== exp_val)
				begin
					errs++;
					$display("Fail result: expected 0x%h, got 0x%h", exp_val, result);
				end
				if (cyc - sent_cyc != LAT)
				begin
					errs++;
					$display("Result came %0d cycles after its strobe instead of %0d",
						cyc - sent_cyc, LAT);
				end
			end
		end
		if (arst_n === 1'b1 && in_valid === 1'b1)
		begin
			exp_q.push_back(ref_product(data_a, data_b, mode)); // Model the strobe.
			cyc_q.push_back(cyc);
			strobes++;
			seen_strobe = 1'b1;
		end
		depth = exp_q.size();
		cyc++;
	end

endmodule

//--- hdl/split_mult.sv
`timescale 1ns/1ns

module split_mult
	import split_mult_pkg::*;
#(
	parameter int A_W  = DEF_A_W, // Width of data_a.
	parameter int B_W  = DEF_B_W, // Width of data_b.
	parameter int LO_W = DEF_LO_W // Split point, below A_W and B_W.
)
(
	input  logic                 clk,       // Core clock.
	input  logic                 arst_n,    // Async reset, active low.
	input  logic                 in_valid,  // One-cycle transaction strobe.
	input  mult_mode_e           mode,      // Signedness of A and B.
	input  logic [A_W-1:0]       data_a,    // Operand A.
	input  logic [B_W-1:0]       data_b,    // Operand B.
	output logic [A_W+B_W-1:0]   result,    // A x B, truncated to A_W+B_W.
	output logic                 out_valid  // Marks result, two cycles later.
);

	// Field widths.
	localparam int AH_W = A_W - LO_W;       // High field of A.
	localparam int BH_W = B_W - LO_W;       // High field of B.

	// Partial product widths, each with its guard bit.
	localparam int HL_W = AH_W + LO_W + 1;  // a_hi x b_lo.
	localparam int AP_W = A_W + BH_W + 1;   // A x b_hi.
	localparam int LL_W = 2 * LO_W + 1;     // a_lo x b_lo.

	// Pipeline depth from strobe to out_valid.
	localparam int LAT = 2;

	logic            a_signed; // A read as two's complement.
	logic            b_signed; // B read as two's complement.

	logic [AH_W-1:0] a_hi;     // Top of A, carries the sign of A.
	logic [LO_W-1:0] a_lo;     // Bottom of A, always unsigned.
	logic [BH_W-1:0] b_hi;     // Top of B, carries the sign of B.
	logic [LO_W-1:0] b_lo;     // Bottom of B, always unsigned.

	logic [HL_W-1:0] prod_hl;  // Stage one products.
	logic [AP_W-1:0] prod_ah;
	logic [LL_W-1:0] prod_ll;

	logic [LAT-1:0]  valid_sr; // Follows the data pipeline.

	// Mode decode.
	always_comb
	begin
		case (mode)
			MODE_UU:
			begin
				a_signed = 1'b0;
				b_signed = 1'b0;
			end
			MODE_US:
			begin
				a_signed = 1'b0;
				b_signed = 1'b1; // Only B is signed.
			end
			MODE_SU:
			begin
				a_signed = 1'b1; // Only A is signed.
				b_signed = 1'b0;
			end
			default:
			begin
				a_signed = 1'b1; // MODE_SS.
				b_signed = 1'b1;
			end
		endcase
	end

	// Operand slicing at the split point.
	assign a_hi = data_a[A_W-1:LO_W]; // Weight 2**LO_W.
	assign a_lo = data_a[LO_W-1:0];   // Weight one.
	assign b_hi = data_b[B_W-1:LO_W]; // Weight 2**LO_W.
	assign b_lo = data_b[LO_W-1:0];   // Weight one.

	// A x B = (a_hi*b_lo + A*b_hi) * 2**LO_W + a_lo*b_lo.
	// A*b_hi holds the a_hi*b_hi and a_lo*b_hi terms together.
	partial_mult
	#(
		.AW (AH_W),
		.BW (LO_W)
	)
	u_mult_hl
	(
		.clk      (clk),
		.arst_n   (arst_n),
		.op_a     (a_hi),
		.op_b     (b_lo),
		.a_signed (a_signed),
		.b_signed (1'b0),     // Low field has no sign.
		.prod     (prod_hl)
	);

	partial_mult
	#(
		.AW (A_W),
		.BW (BH_W)
	)
	u_mult_ah
	(
		.clk      (clk),
		.arst_n   (arst_n),
		.op_a     (data_a),   // Whole of A.
		.op_b     (b_hi),
		.a_signed (a_signed),
		.b_signed (b_signed),
		.prod     (prod_ah)
	);

	partial_mult
	#(
		.AW (LO_W),
		.BW (LO_W)
	)
	u_mult_ll
	(
		.clk      (clk),
		.arst_n   (arst_n),
		.op_a     (a_lo),
		.op_b     (b_lo),
		.a_signed (1'b0),     // Both low fields unsigned.
		.b_signed (1'b0),
		.prod     (prod_ll)
	);

	// Shift-and-add end stage.
	partial_combine
	#(
		.A_W  (A_W),
		.B_W  (B_W),
		.LO_W (LO_W)
	)
	u_combine
	(
		.clk     (clk),
		.arst_n  (arst_n),
		.prod_hl (prod_hl),
		.prod_ah (prod_ah),
		.prod_ll (prod_ll),
		.result  (result)
	);

	// Valid pipeline, one bit per data stage.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			valid_sr <= '0; // Nothing in flight.
		end
		else
		begin
			valid_sr <= {valid_sr[LAT-2:0], in_valid}; // Shift with the data.
		end
	end

	assign out_valid = valid_sr[LAT-1]; // Lines up with the result register.

endmodule

//--- hdl/partial_combine.sv
`timescale 1ns/1ns

module partial_combine
	import split_mult_pkg::*;
#(
	parameter int A_W  = DEF_A_W, // Width of operand A.
	parameter int B_W  = DEF_B_W, // Width of operand B.
	parameter int LO_W = DEF_LO_W // Split point of both operands.
)
(
	input  logic                     clk,     // Core clock.
	input  logic                     arst_n,  // Async reset, active low.
	input  logic [A_W:0]             prod_hl, // a_hi x b_lo, signed.
	input  logic [A_W+B_W-LO_W:0]    prod_ah, // A x b_hi, signed.
	input  logic [2*LO_W:0]          prod_ll, // a_lo x b_lo, never negative.
	output logic [A_W+B_W-1:0]       result   // Full product, registered.
);

	localparam int P_W  = A_W + B_W;    // Product width.
	localparam int UP_W = P_W - LO_W;   // Bits of result above the split.
	localparam int HL_W = A_W + 1;      // Width of prod_hl.
	localparam int AH_W = UP_W + 1;     // Width of prod_ah.
	localparam int LL_W = 2 * LO_W + 1; // Width of prod_ll.
	localparam int LH_W = LL_W - LO_W;  // Upper part of prod_ll.

	logic [AH_W-1:0] hl_ext;   // prod_hl sign extended to the prod_ah width.
	logic [AH_W-1:0] hi_sum;   // Both cross terms, weight 2**LO_W.
	logic [LH_W-1:0] ll_hi;    // prod_ll bits at and above the split.
	logic [LO_W-1:0] ll_lo;    // prod_ll bits below the split.
	logic [UP_W-1:0] ll_hi_ext; // Upper part of prod_ll padded to UP_W.
	logic [AH_W-1:0] upper;    // Everything at weight 2**LO_W and above.

	// Cross terms are signed, extend with their top bit.
	assign hl_ext = {{(AH_W - HL_W){prod_hl[HL_W-1]}}, prod_hl}; // B_W-LO_W copies.

	// First adder, both terms already line up at 2**LO_W.
	assign hi_sum = hl_ext + prod_ah; // Wraps like the final product does.

	// prod_ll sits at weight one.
	// Its low LO_W bits meet nothing else and go straight to the result.
	assign ll_lo = prod_ll[LO_W-1:0];   // Bypass the adder.
	assign ll_hi = prod_ll[LL_W-1:LO_W]; // Carries into the upper sum.

	assign ll_hi_ext = {{(UP_W - LH_W){1'b0}}, ll_hi}; // Unsigned, zero pad.

	// Second adder. Only UP_W bits survive.
	assign upper = hi_sum + {1'b0, ll_hi_ext}; // Top bit falls off below.

	// End-stage register, low P_W bits of the aligned sum.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			result <= '0; // Clean output in reset.
		end
		else
		begin
			result <= {upper[UP_W-1:0], ll_lo}; // Shifted sum over low bits.
		end
	end

endmodule

//--- hdl/partial_mult.sv
`timescale 1ns/1ns

module partial_mult
#(
	parameter int AW = 8, // Width of op_a.
	parameter int BW = 8  // Width of op_b.
)
(
	input  logic              clk,      // Core clock.
	input  logic              arst_n,   // Async reset, active low.
	input  logic [AW-1:0]     op_a,     // First field.
	input  logic [BW-1:0]     op_b,     // Second field.
	input  logic              a_signed, // Read op_a as two's complement.
	input  logic              b_signed, // Read op_b as two's complement.
	output logic [AW+BW:0]    prod      // Registered product, one spare bit.
);

	// Product width with the guard bit.
	// (AW+1) x (BW+1) signed would need AW+BW+2 bits, but the extended
	// operands never reach their most negative value, so one bit less is exact.
	localparam int P_W = AW + BW + 1;

	logic              a_ext_bit;  // Extension bit of op_a.
	logic              b_ext_bit;  // Extension bit of op_b.
	logic signed [AW:0] a_ext;     // op_a widened by one bit.
	logic signed [BW:0] b_ext;     // op_b widened by one bit.
	logic signed [P_W-1:0] prod_c; // Combinational product.

	// Sign bit copies up only when the field is signed.
	assign a_ext_bit = a_signed & op_a[AW-1]; // Zero fill when unsigned.
	assign b_ext_bit = b_signed & op_b[BW-1]; // Zero fill when unsigned.

	assign a_ext = $signed({a_ext_bit, op_a}); // Now always a signed value.
	assign b_ext = $signed({b_ext_bit, op_b}); // Same for the B side.

	// Both sides are signed here, so the tool builds one signed multiplier
	// and every mix of signedness comes out of the same array.
	assign prod_c = a_ext * b_ext; // Extended to P_W before the multiply.

	// One pipeline stage.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			prod <= '0; // Product reads zero in reset.
		end
		else
		begin
			prod <= prod_c; // Launch the product.
		end
	end

endmodule

//--- hdl/split_mult_pkg.sv
package split_mult_pkg;

	// Operand signedness per transaction.
	// The first letter is operand A, the second is operand B.
	typedef enum logic [1:0]
	{
		MODE_UU = 2'b00, // Both operands unsigned.
		MODE_US = 2'b01, // A unsigned, B signed.
		MODE_SU = 2'b10, // A signed, B unsigned.
		MODE_SS = 2'b11  // Both operands signed.
	} mult_mode_e;

	// Default operand widths.
	localparam int DEF_A_W = 12; // Width of data_a.
	localparam int DEF_B_W = 12; // Width of data_b.

	// Split point, the width of each low field.
	// The high fields get what is left of each operand.
	localparam int DEF_LO_W = 9; // Low field of both operands.

endpackage
